//--- include/rx_config.svh
/*
 * rx config
 * constants of the 8b/10b receive path: comma patterns in line order,
 * FIFO depth, error counter width and assembled word width
 */
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// bit 0 of each pattern is the first bit on the line (a), bit 9 is j
`define RX_COMMA_NEG 10'b0101111100  // abcdei fghj = 001111 1010
`define RX_COMMA_POS 10'b1010000011  // abcdei fghj = 110000 0101

`define RX_FIFO_ALOG2 4  // 16 words deep

`define RX_CNT_W 8  // saturating error counters

`define RX_WORD_W 24  // three data bytes per word

`endif

//--- verilog/rx_pkg.sv
/*
 * rx package
 * enum types of the 8b/10b receive path shared by RTL and testbench
 */
package rx_pkg;

    // symbol aligner lock state
    typedef enum logic {
        ALIGN_HUNT,
        ALIGN_LOCKED
    } align_state_t;

    // four-phase req/ack on the FIFO read side
    typedef enum logic [1:0] {
        HS_IDLE,      // waiting for a word and ack low
        HS_REQ,       // req up, data held
        HS_WAIT_LOW   // popped, waiting for ack to drop
    } hs_state_t;

    // accepted control characters, value is the decoded byte
    typedef enum logic [7:0] {
        K28_0 = 8'h1C,
        K28_1 = 8'h3C,
        K28_5 = 8'hBC,  // comma
        K23_7 = 8'hF7,
        K27_7 = 8'hFB,
        K29_7 = 8'hFD,
        K30_7 = 8'hFE
    } k_code_t;

endpackage

//--- verilog/symbol_aligner.sv
/*
 * symbol aligner
 * shifts the serial line into a 10-bit window, hunts for the K28.5 comma
 * and, once locked, strobes one symbol every ten bits
 * re-phases on any comma seen while locked
 */
`timescale 1ns/1ns
`default_nettype none
`include "rx_config.svh"

module symbol_aligner import rx_pkg::*; (
    input  wire logic       WCLK,
    input  wire logic       RESET_WCLK,
    input  wire logic       rx_data,
    input  wire logic       invert_rx_data,
    output logic [9:0]      sym_data,       // bit 0 is first on the line
    output logic            sym_valid,
    output logic            rec_sync_ready
);

    align_state_t state;
    logic [9:0]   window;       // last ten line bits, oldest in bit 0
    logic [3:0]   phase;        // bits since the last strobe
    logic         line_bit;
    logic         comma_hit;
    logic         take_sym;     // window holds a whole symbol

    assign line_bit = rx_data ^ invert_rx_data;  // optional polarity flip

    // either disparity of K28.5
    assign comma_hit = (window == `RX_COMMA_NEG) || (window == `RX_COMMA_POS);

    assign take_sym = comma_hit || ((state == ALIGN_LOCKED) && (phase == 4'd9));

    // newest bit enters at the top
    always_ff @(posedge WCLK) begin
        window <= {line_bit, window[9:1]};
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            state     <= ALIGN_HUNT;
            phase     <= 4'd0;
            sym_valid <= 1'b0;
        end else begin
            sym_valid <= take_sym;
            case (state)
                ALIGN_HUNT: begin
                    phase <= 4'd0;
                    if (comma_hit) begin
                        state <= ALIGN_LOCKED;  // comma itself goes out next cycle
                    end
                end
                ALIGN_LOCKED: begin
                    if (take_sym) begin
                        phase <= 4'd0;          // comma at another phase moves us
                    end else begin
                        phase <= phase + 4'd1;
                    end
                end
                default: state <= ALIGN_HUNT;
            endcase
        end
    end

    // symbol register, loaded with the strobe
    always_ff @(posedge WCLK) begin
        if (take_sym) begin
            sym_data <= window;
        end
    end

    assign rec_sync_ready = (state == ALIGN_LOCKED);

endmodule

`default_nettype wire

//--- verilog/decode_8b10b.sv
/*
 * 8b/10b decoder
 * reverses the line-order symbol into abcdei fghj, decodes both sub-blocks,
 * checks code and running disparity and registers byte, k flag and error
 * running disparity only advances on good symbols
 */
`timescale 1ns/1ns
`default_nettype none

module decode_8b10b import rx_pkg::*; (
    input  wire logic       WCLK,
    input  wire logic       RESET_WCLK,
    input  wire logic       sym_valid,
    input  wire logic [9:0] sym_data,
    output logic [7:0]      dec_byte,
    output logic            dec_k,
    output logic            dec_err,
    output logic            dec_valid
);

    logic [9:0] code;       // a in bit 9, j in bit 0
    logic [5:0] b6;         // abcdei
    logic [3:0] b4;         // fghj
    logic [3:0] b4_dec;
    logic [5:0] d6;         // {valid, EDCBA}
    logic [3:0] d4;         // {valid, HGF}
    logic       rd;         // running disparity, 1 = positive
    logic       rd_mid, rd_out;
    logic       pos6, neg6, pos4, neg4;
    logic       err6, err4;
    logic       is_k28, is_kx7, is_k, k_known;
    logic       code_err, disp_err;
    logic [7:0] byte_dec;

    // 5b/6b, both disparity forms per line
    function automatic logic [5:0] dec_5b6b(input logic [5:0] v);
        case (v)
            6'b100111, 6'b011000: dec_5b6b = {1'b1, 5'd0};
            6'b011101, 6'b100010: dec_5b6b = {1'b1, 5'd1};
            6'b101101, 6'b010010: dec_5b6b = {1'b1, 5'd2};
            6'b110001:            dec_5b6b = {1'b1, 5'd3};
            6'b110101, 6'b001010: dec_5b6b = {1'b1, 5'd4};
            6'b101001:            dec_5b6b = {1'b1, 5'd5};
            6'b011001:            dec_5b6b = {1'b1, 5'd6};
            6'b111000, 6'b000111: dec_5b6b = {1'b1, 5'd7};
            6'b111001, 6'b000110: dec_5b6b = {1'b1, 5'd8};
            6'b100101:            dec_5b6b = {1'b1, 5'd9};
            6'b010101:            dec_5b6b = {1'b1, 5'd10};
            6'b110100:            dec_5b6b = {1'b1, 5'd11};
            6'b001101:            dec_5b6b = {1'b1, 5'd12};
            6'b101100:            dec_5b6b = {1'b1, 5'd13};
            6'b011100:            dec_5b6b = {1'b1, 5'd14};
            6'b010111, 6'b101000: dec_5b6b = {1'b1, 5'd15};
            6'b011011, 6'b100100: dec_5b6b = {1'b1, 5'd16};
            6'b100011:            dec_5b6b = {1'b1, 5'd17};
            6'b010011:            dec_5b6b = {1'b1, 5'd18};
            6'b110010:            dec_5b6b = {1'b1, 5'd19};
            6'b001011:            dec_5b6b = {1'b1, 5'd20};
            6'b101010:            dec_5b6b = {1'b1, 5'd21};
            6'b011010:            dec_5b6b = {1'b1, 5'd22};
            6'b111010, 6'b000101: dec_5b6b = {1'b1, 5'd23};
            6'b110011, 6'b001100: dec_5b6b = {1'b1, 5'd24};
            6'b100110:            dec_5b6b = {1'b1, 5'd25};
            6'b010110:            dec_5b6b = {1'b1, 5'd26};
            6'b110110, 6'b001001: dec_5b6b = {1'b1, 5'd27};
            6'b001110,
            6'b001111, 6'b110000: dec_5b6b = {1'b1, 5'd28};  // D.28 and K.28
            6'b101110, 6'b010001: dec_5b6b = {1'b1, 5'd29};
            6'b011110, 6'b100001: dec_5b6b = {1'b1, 5'd30};
            6'b101011, 6'b010100: dec_5b6b = {1'b1, 5'd31};
            default:              dec_5b6b = 6'd0;           // 000011, 111100 etc
        endcase
    endfunction

    // 3b/4b, primary and alternate 7 both accepted
    function automatic logic [3:0] dec_3b4b(input logic [3:0] v);
        case (v)
            4'b1011, 4'b0100: dec_3b4b = {1'b1, 3'd0};
            4'b1001:          dec_3b4b = {1'b1, 3'd1};
            4'b0101:          dec_3b4b = {1'b1, 3'd2};
            4'b1100, 4'b0011: dec_3b4b = {1'b1, 3'd3};
            4'b1101, 4'b0010: dec_3b4b = {1'b1, 3'd4};
            4'b1010:          dec_3b4b = {1'b1, 3'd5};
            4'b0110:          dec_3b4b = {1'b1, 3'd6};
            4'b1110, 4'b0001,
            4'b0111, 4'b1000: dec_3b4b = {1'b1, 3'd7};
            default:          dec_3b4b = 4'd0;
        endcase
    endfunction

    // line order to decode order
    always_comb begin
        for (int i = 0; i < 10; i++) begin
            code[9-i] = sym_data[i];
        end
    end

    assign b6 = code[9:4];
    assign b4 = code[3:0];

    assign is_k28 = (b6 == 6'b001111) || (b6 == 6'b110000);
    assign b4_dec = (b6 == 6'b110000) ? ~b4 : b4;  // K.28 after 110000 sends fghj inverted
    assign d6     = dec_5b6b(b6);
    assign d4     = dec_3b4b(b4_dec);
    assign byte_dec = {d4[2:0], d6[4:0]};

    // Kx.7 uses the alternate 7 after x = 23, 27, 29, 30
    assign is_kx7 = ((b4 == 4'b1000) || (b4 == 4'b0111)) &&
                    ((d6[4:0] == 5'd23) || (d6[4:0] == 5'd27) ||
                     (d6[4:0] == 5'd29) || (d6[4:0] == 5'd30));
    assign is_k   = is_k28 || is_kx7;

    always_comb begin
        case (k_code_t'(byte_dec))
            K28_0, K28_1, K28_5, K23_7, K27_7, K29_7, K30_7: k_known = 1'b1;
            default: k_known = 1'b0;
        endcase
    end

    // disparity per sub-block
    assign pos6   = ($countones(b6) == 4);
    assign neg6   = ($countones(b6) == 2);
    assign err6   = (pos6 && rd) || (neg6 && !rd) ||
                    ((b6 == 6'b111000) && rd) || ((b6 == 6'b000111) && !rd);
    assign rd_mid = pos6 ? 1'b1 : (neg6 ? 1'b0 : rd);

    assign pos4   = ($countones(b4) == 3);
    assign neg4   = ($countones(b4) == 1);
    assign err4   = (pos4 && rd_mid) || (neg4 && !rd_mid) ||
                    ((b4 == 4'b1100) && rd_mid) || ((b4 == 4'b0011) && !rd_mid);
    assign rd_out = pos4 ? 1'b1 : (neg4 ? 1'b0 : rd_mid);

    assign code_err = !d6[5] || !d4[3] || (is_k && !k_known);
    assign disp_err = err6 || err4;

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            rd        <= 1'b0;                  // start negative
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= sym_valid;
            if (sym_valid && !(code_err || disp_err)) begin
                rd <= rd_out;                   // bad symbol keeps old rd
            end
        end
    end

    always_ff @(posedge WCLK) begin
        if (sym_valid) begin
            dec_byte <= byte_dec;
            dec_k    <= is_k;
            dec_err  <= code_err || disp_err;
        end
    end

endmodule

`default_nettype wire

//--- verilog/word_assembler.sv
/*
 * word assembler
 * packs three consecutive good data bytes into one word, first byte on top
 * a control character or a bad symbol drops the partial word
 * counts decode errors with saturation
 */
`timescale 1ns/1ns
`default_nettype none
`include "rx_config.svh"

module word_assembler (
    input  wire logic                WCLK,
    input  wire logic                RESET_WCLK,
    input  wire logic                dec_k,
    input  wire logic                dec_err,
    input  wire logic                dec_valid,
    input  wire logic [7:0]          dec_byte,
    output logic [`RX_WORD_W-1:0]    word_data,
    output logic                     word_valid,
    output logic [`RX_CNT_W-1:0]     decoder_err_cnt
);

    logic [1:0] byte_sel;   // next slot, 0 is msb byte
    logic [7:0] byte_hi;
    logic [7:0] byte_mid;
    logic       good_byte;
    logic       last_byte;

    assign good_byte = dec_valid && !dec_k && !dec_err;
    assign last_byte = good_byte && (byte_sel == 2'd2);

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            byte_sel   <= 2'd0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= last_byte;
            if (dec_valid) begin
                if (!good_byte || last_byte) begin
                    byte_sel <= 2'd0;  // resync or word done
                end else begin
                    byte_sel <= byte_sel + 2'd1;
                end
            end
        end
    end

    // byte slots
    always_ff @(posedge WCLK) begin
        if (good_byte) begin
            case (byte_sel)
                2'd0:    byte_hi  <= dec_byte;
                2'd1:    byte_mid <= dec_byte;
                default: word_data <= {byte_hi, byte_mid, dec_byte};
            endcase
        end
    end

    // errored symbols, stops at all ones
    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            decoder_err_cnt <= '0;
        end else if (dec_valid && dec_err && (decoder_err_cnt != {`RX_CNT_W{1'b1}})) begin
            decoder_err_cnt <= decoder_err_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/word_fifo.sv
/*
 * word FIFO
 * circular buffer for assembled words with a four-phase req/ack read side
 * words arriving while full are dropped and counted
 */
`timescale 1ns/1ns
`default_nettype none
`include "rx_config.svh"

module word_fifo import rx_pkg::*; (
    input  wire logic                   WCLK,
    input  wire logic                   RESET_WCLK,
    input  wire logic                   word_valid,
    input  wire logic                   out_ack,
    input  wire logic [`RX_WORD_W-1:0]  word_data,
    output logic [`RX_WORD_W-1:0]       out_data,
    output logic                        out_req,
    output logic [`RX_FIFO_ALOG2:0]     fifo_size,
    output logic [`RX_CNT_W-1:0]        lost_err_cnt
);

    localparam int DEPTH = 1 << `RX_FIFO_ALOG2;

    logic [`RX_WORD_W-1:0]     mem [DEPTH];
    logic [`RX_FIFO_ALOG2-1:0] wr_ptr;
    logic [`RX_FIFO_ALOG2-1:0] rd_ptr;
    hs_state_t                 hs_state;
    logic                      full;
    logic                      push;
    logic                      pop;
    logic                      start;

    assign full  = (fifo_size == (`RX_FIFO_ALOG2+1)'(DEPTH));
    assign push  = word_valid && !full;
    assign pop   = (hs_state == HS_REQ) && out_ack;                     // pop on ack
    assign start = (hs_state == HS_IDLE) && (fifo_size != '0) && !out_ack;

    always_ff @(posedge WCLK) begin
        if (push) begin
            mem[wr_ptr] <= word_data;
        end
        if (start) begin
            out_data <= mem[rd_ptr];  // held for the whole req phase
        end
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fifo_size <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            fifo_size <= fifo_size + (`RX_FIFO_ALOG2+1)'(push) - (`RX_FIFO_ALOG2+1)'(pop);
        end
    end

    // req/ack sequence
    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            hs_state <= HS_IDLE;
        end else begin
            case (hs_state)
                HS_IDLE:     if (start)    hs_state <= HS_REQ;
                HS_REQ:      if (out_ack)  hs_state <= HS_WAIT_LOW;
                HS_WAIT_LOW: if (!out_ack) hs_state <= HS_IDLE;      // ack released
                default:     hs_state <= HS_IDLE;
            endcase
        end
    end

    assign out_req = (hs_state == HS_REQ);

    // words lost to overflow
    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            lost_err_cnt <= '0;
        end else if (word_valid && full && (lost_err_cnt != {`RX_CNT_W{1'b1}})) begin
            lost_err_cnt <= lost_err_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/receiver_logic.sv
/*
 * receiver logic
 * serial 8b/10b receive path on WCLK
 * align, decode, assemble 24-bit words, buffer with req/ack out
 */
`timescale 1ns/1ns
`default_nettype none
`include "rx_config.svh"

module receiver_logic (
    input  wire logic                WCLK,
    input  wire logic                RESET_WCLK,
    input  wire logic                rx_data,
    input  wire logic                invert_rx_data,
    input  wire logic                out_ack,
    output logic [`RX_WORD_W-1:0]    out_data,
    output logic                     out_req,
    output logic                     rec_sync_ready,
    output logic [`RX_CNT_W-1:0]     decoder_err_cnt,
    output logic [`RX_CNT_W-1:0]     lost_err_cnt,
    output logic [`RX_FIFO_ALOG2:0]  fifo_size
);

    logic [9:0]            sym_data;    // aligner to decoder
    logic                  sym_valid;
    logic [7:0]            dec_byte;    // decoder to assembler
    logic                  dec_k;
    logic                  dec_err;
    logic                  dec_valid;
    logic [`RX_WORD_W-1:0] word_data;   // assembler to FIFO
    logic                  word_valid;

    symbol_aligner u_aligner (
        .WCLK           (WCLK),
        .RESET_WCLK     (RESET_WCLK),
        .rx_data        (rx_data),
        .invert_rx_data (invert_rx_data),
        .sym_data       (sym_data),
        .sym_valid      (sym_valid),
        .rec_sync_ready (rec_sync_ready)
    );

    decode_8b10b u_decoder (
        .WCLK       (WCLK),
        .RESET_WCLK (RESET_WCLK),
        .sym_valid  (sym_valid),
        .sym_data   (sym_data),
        .dec_byte   (dec_byte),
        .dec_k      (dec_k),
        .dec_err    (dec_err),
        .dec_valid  (dec_valid)
    );

    word_assembler u_assembler (
        .WCLK            (WCLK),
        .RESET_WCLK      (RESET_WCLK),
        .dec_k           (dec_k),
        .dec_err         (dec_err),
        .dec_valid       (dec_valid),
        .dec_byte        (dec_byte),
        .word_data       (word_data),
        .word_valid      (word_valid),
        .decoder_err_cnt (decoder_err_cnt)
    );

    word_fifo u_fifo (
        .WCLK         (WCLK),
        .RESET_WCLK   (RESET_WCLK),
        .word_valid   (word_valid),
        .out_ack      (out_ack),
        .word_data    (word_data),
        .out_data     (out_data),
        .out_req      (out_req),
        .fifo_size    (fifo_size),
        .lost_err_cnt (lost_err_cnt)
    );

endmodule

`default_nettype wire

//--- verif/line_encoder.sv
/*
 * line encoder
 * behavioural 8b/10b transmitter for the testbench
 * encodes data bytes and K28.y with its own running disparity
 * and shifts each symbol out a first, one bit per falling edge
 */
`timescale 1ns/1ns
`default_nettype none

module line_encoder import rx_pkg::*; (
    input  wire logic WCLK,
    output logic      line_bit
);

    logic rd;  // 1 = positive

    initial begin
        line_bit = 1'b0;
        rd       = 1'b0;
    end

    // 5b/6b, RD- column, abcdei
    function automatic logic [5:0] code_5b6b(input logic [4:0] x);
        logic [5:0] t [32];
        t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001,
              6'b011001, 6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100,
              6'b001101, 6'b101100, 6'b011100, 6'b010111, 6'b011011, 6'b100011,
              6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
              6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110,
              6'b011110, 6'b101011};
        return t[x];
    endfunction

    // 3b/4b, RD- column, fghj, primary 7
    function automatic logic [3:0] code_3b4b(input logic [2:0] y);
        logic [3:0] t [8];
        t = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
        return t[y];
    endfunction

    task automatic clear_disparity();
        rd = 1'b0;
    endtask

    // code has a in bit 9
    task automatic send_raw(input logic [9:0] code);
        for (int i = 9; i >= 0; i--) begin
            @(negedge WCLK);
            line_bit = code[i];
        end
    endtask

    // k selects K28.y with y from b[7:5]
    task automatic send_symbol(input logic [7:0] b, input logic k);
        logic [5:0] s6;
        logic [3:0] s4;
        logic       alt;
        s6 = k ? 6'b001111 : code_5b6b(b[4:0]);
        if (rd && (($countones(s6) != 3) || (s6 == 6'b111000))) s6 = ~s6;
        if ($countones(s6) != 3) rd = ~rd;  // unbalanced flips rd
        s4 = code_3b4b(b[7:5]);
        if (!k && (b[7:5] == 3'd7)) begin
            // alternate 7 keeps a run of five out of the data
            if (rd) alt = (b[4:0] == 5'd11) || (b[4:0] == 5'd13) || (b[4:0] == 5'd14);
            else    alt = (b[4:0] == 5'd17) || (b[4:0] == 5'd18) || (b[4:0] == 5'd20);
            if (alt) s4 = 4'b0111;
        end
        if (rd && (($countones(s4) != 2) || (s4 == 4'b1100))) s4 = ~s4;
        // K28 after 110000 sends fghj inverted
        if (k && !rd && ($countones(s4) == 2) && (b[7:5] != 3'd3)) s4 = ~s4;
        if ($countones(s4) != 2) rd = ~rd;
        send_raw({s6, s4});
    endtask

endmodule

`default_nettype wire

//--- verif/tb_receiver_logic.sv
/*
 * receiver logic testbench
 * random 8b/10b traffic from line_encoder, word model built from the
 * sent stream, req/ack consumer with random delays
 * covers lock, data order, resync, decode errors and FIFO overflow
 */
`timescale 1ns/1ns
`default_nettype none
`include "rx_config.svh"

module tb_receiver_logic import rx_pkg::*; ();

    localparam int DEPTH         = 1 << `RX_FIFO_ALOG2;
    localparam int DATA_BYTES    = 200;
    localparam int RESYNC_GROUPS = 12;
    localparam int INJECTS       = 5;
    localparam int HOLD_WORDS    = 22;
    localparam int DRAIN_SYMS    = 30;  // generous count of idle commas per drain
    localparam int SYMS = 2 * 7 + (DATA_BYTES + 2) + (RESYNC_GROUPS * 9 + 2)
                        + (INJECTS * 9 + 8) + (HOLD_WORDS * 3 + 5) + 4 * DRAIN_SYMS;
    localparam int CYCLE_LIMIT = SYMS * 10 * 2 + 2000;

    logic                     WCLK;
    logic                     RESET_WCLK;
    logic                     invert_rx_data;
    logic                     out_ack;
    logic                     enc_line;
    logic                     rx_data;
    logic [`RX_WORD_W-1:0]    out_data;
    logic                     out_req;
    logic                     rec_sync_ready;
    logic [`RX_CNT_W-1:0]     decoder_err_cnt;
    logic [`RX_CNT_W-1:0]     lost_err_cnt;
    logic [`RX_FIFO_ALOG2:0]  fifo_size;

    logic [31:0]              lcg_state;
    logic [`RX_WORD_W-1:0]    exp_q [$];  // words the DUT still owes
    int                       errors;
    int                       checks;
    int                       cycles;
    logic                     hold_ack;       // consumer stops acking
    logic                     consumer_busy;
    logic                     model_locked;
    int                       model_nbytes;
    logic [`RX_WORD_W-1:0]    model_part;
    int                       model_held;
    int                       lost_exp;

    assign rx_data = enc_line ^ invert_rx_data;  // line polarity matches the DUT setting

    line_encoder enc0 (
        .WCLK     (WCLK),
        .line_bit (enc_line)
    );

    receiver_logic dut0 (
        .WCLK            (WCLK),
        .RESET_WCLK      (RESET_WCLK),
        .rx_data         (rx_data),
        .invert_rx_data  (invert_rx_data),
        .out_ack         (out_ack),
        .out_data        (out_data),
        .out_req         (out_req),
        .rec_sync_ready  (rec_sync_ready),
        .decoder_err_cnt (decoder_err_cnt),
        .lost_err_cnt    (lost_err_cnt),
        .fifo_size       (fifo_size)
    );

    initial begin
        WCLK = 1'b0;
        forever #20 WCLK = ~WCLK;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("problem: %s", what);
    endtask

    // expected words from the sent stream
    task automatic model_symbol(input logic [7:0] b, input logic k, input logic bad);
        if (k && (b == K28_5)) model_locked = 1'b1;
        if (model_locked) begin
            if (k || bad) begin
                model_nbytes = 0;  // partial word gone
            end else begin
                model_part = {model_part[15:0], b};
                model_nbytes++;
                if (model_nbytes == 3) begin
                    model_nbytes = 0;
                    if (hold_ack && (model_held >= DEPTH)) begin
                        lost_exp++;
                    end else begin
                        exp_q.push_back(model_part);
                        if (hold_ack) model_held++;
                    end
                end
            end
        end
    endtask

    task automatic send_char(input logic [7:0] b, input logic k);
        model_symbol(b, k, 1'b0);
        enc0.send_symbol(b, k);
    endtask

    task automatic send_bad();
        model_symbol(8'h00, 1'b0, 1'b1);
        enc0.send_raw(10'd0);  // invalid 6b and 4b
    endtask

    task automatic send_data(input int n);
        repeat (n) send_char(8'(lcg_next() >> 16), 1'b0);
    endtask

    // commas keep the line busy until all words are out
    task automatic drain();
        while ((exp_q.size() != 0) || consumer_busy) send_char(K28_5, 1'b1);
    endtask

    task automatic reset_dut(input logic inv);
        @(negedge WCLK);
        RESET_WCLK     = 1'b1;
        invert_rx_data = inv;
        repeat (8) @(negedge WCLK);
        RESET_WCLK = 1'b0;
        enc0.clear_disparity();
        model_locked = 1'b0;
        model_nbytes = 0;
        model_held   = 0;
        lost_exp     = 0;
        exp_q.delete();
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("test %s: %s, %0d errors", name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    // consumer side of the req/ack handshake
    initial begin : consumer
        logic [`RX_WORD_W-1:0] held;
        int                    delay;
        out_ack       = 1'b0;
        consumer_busy = 1'b0;
        forever begin
            @(negedge WCLK);
            if (out_req && !hold_ack) begin
                consumer_busy = 1'b1;
                held  = out_data;
                delay = int'(lcg_next() >> 16) % 8;
                repeat (delay) begin
                    @(negedge WCLK);
                    if (!out_req || (out_data !== held)) begin
                        report_problem("out_req dropped or out_data moved before ack");
                    end
                end
                if (exp_q.size() == 0) begin
                    report_problem("out_req raised with no word left in the model");
                end else begin
                    compare_value("out_data", out_data, exp_q.pop_front());
                end
                out_ack = 1'b1;
                do @(negedge WCLK); while (out_req);
                out_ack       = 1'b0;
                consumer_busy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge WCLK);
            cycles++;
        end
        $display("run stopped by timeout after %0d cycles", cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        int e0;
        lcg_state      = 32'd22;
        errors         = 0;
        checks         = 0;
        hold_ack       = 1'b0;
        RESET_WCLK     = 1'b1;
        invert_rx_data = 1'b0;
        model_locked   = 1'b0;
        model_nbytes   = 0;
        model_part     = '0;
        model_held     = 0;
        lost_exp       = 0;

        // lock with both polarities
        e0 = errors;
        for (int inv = 0; inv < 2; inv++) begin
            reset_dut(inv[0]);
            repeat (3) begin
                enc0.send_raw(10'd0);  // no comma yet
                compare_value("rec_sync_ready", rec_sync_ready, 0);
                compare_value("out_req", out_req, 0);
            end
            repeat (4) send_char(K28_5, 1'b1);
            compare_value("rec_sync_ready", rec_sync_ready, 1);
            // an unflipped line shows the first comma with the wrong disparity
            compare_value("decoder_err_cnt", decoder_err_cnt, 0);
        end
        end_test("lock", e0);

        // random bytes in order
        e0 = errors;
        reset_dut(1'b0);
        repeat (2) send_char(K28_5, 1'b1);
        send_data(DATA_BYTES);
        drain();
        compare_value("decoder_err_cnt", decoder_err_cnt, 0);
        end_test("data order", e0);

        // K28.1 cuts partial words
        e0 = errors;
        reset_dut(1'b0);
        repeat (2) send_char(K28_5, 1'b1);
        for (int g = 0; g < RESYNC_GROUPS; g++) begin
            send_data(1 + int'(lcg_next() >> 16) % 2);
            send_char(K28_1, 1'b1);
            send_data(6);
        end
        drain();
        compare_value("decoder_err_cnt", decoder_err_cnt, 0);
        end_test("resync", e0);

        // all-zero symbols
        e0 = errors;
        reset_dut(1'b0);
        repeat (2) send_char(K28_5, 1'b1);
        for (int i = 0; i < INJECTS; i++) begin
            send_data(4 + int'(lcg_next() >> 16) % 5);
            send_bad();
        end
        send_data(6);
        drain();
        compare_value("decoder_err_cnt", decoder_err_cnt, INJECTS);
        end_test("decode errors", e0);

        // ack held until the FIFO overflows
        e0 = errors;
        reset_dut(1'b0);
        hold_ack = 1'b1;
        repeat (2) send_char(K28_5, 1'b1);
        send_data(3 * HOLD_WORDS);
        repeat (3) send_char(K28_5, 1'b1);  // last word reaches the FIFO
        compare_value("fifo_size", fifo_size, DEPTH);
        compare_value("lost_err_cnt", lost_err_cnt, lost_exp);
        hold_ack = 1'b0;
        drain();
        end_test("back-pressure", e0);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
verilog/rx_pkg.sv
verilog/symbol_aligner.sv
verilog/decode_8b10b.sv
verilog/word_assembler.sv
verilog/word_fifo.sv
verilog/receiver_logic.sv
verif/line_encoder.sv
verif/tb_receiver_logic.sv

//--- Bender.yml
package:
  name: receiver_logic

sources:
  - include_dirs:
      - include
    files:
      - verilog/rx_pkg.sv
      - verilog/symbol_aligner.sv
      - verilog/decode_8b10b.sv
      - verilog/word_assembler.sv
      - verilog/word_fifo.sv
      - verilog/receiver_logic.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/line_encoder.sv
      - verif/tb_receiver_logic.sv
